//--- sources.f
source/arkvid_pkg.sv
source/video_timing.sv
source/apb_regs.sv
source/video_ram.sv
source/tile_fetch.sv
source/palette_lookup.sv
source/video_output.sv
source/arkvid_top.sv
tests/arkvid_checker.sv
tests/tb_arkvid.sv

//--- Bender.yml
package:
  name: arkvid

sources:
  - source/arkvid_pkg.sv
  - source/video_timing.sv
  - source/apb_regs.sv
  - source/video_ram.sv
  - source/tile_fetch.sv
  - source/palette_lookup.sv
  - source/video_output.sv
  - source/arkvid_top.sv
  - target: test
    files:
      - tests/arkvid_checker.sv
      - tests/tb_arkvid.sv

//--- tests/tb_arkvid.sv
/*
 * Testbench for the tilemap video core. Loads the tile map, palette and
 * control register over APB from an xorshift sequence and checks the
 * video outputs against a raster model that runs beside the DUT.
 */
`timescale 1ns/1ns

module tb_arkvid import arkvid_pkg::*; ();

	localparam int LINE_CLKS   = (int'(CNT_MAX) - int'(H_START) + 1) * PIX_DIV;
	localparam int FRAME_LINES = int'(CNT_MAX) - int'(V_BASE) + 1;
	localparam int APB_LIMIT   = 16;
	localparam logic [31:0] CTRL_MASK = (32'h1 << CTRL_HFLIP_BIT) | (32'h1 << CTRL_VFLIP_BIT)
		| (32'h1 << CTRL_BANK_BIT) | (32'h7 << CTRL_VCENTER_LSB) | (32'hf << CTRL_HCENTER_LSB);

	logic        clk_48m;
	logic        rst_n_i;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [12:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic [3:0]  video_r;
	logic [3:0]  video_g;
	logic [3:0]  video_b;
	logic        video_hsync;
	logic        video_vsync;
	logic        video_csync;
	logic        video_hblank;
	logic        video_vblank;

	// Model state: memories, control register, counters and position history
	tile_code_t  tile_m [TILE_MAP_DEPTH];
	rgb_t        pal_m [PAL_DEPTH];
	logic [31:0] ctrl_m;
	cnt_t        m_h;
	cnt_t        m_v;
	int          m_div;
	cnt_t        h_hist [PIPE_DEPTH+1];
	cnt_t        v_hist [PIPE_DEPTH+1];
	int          settle;
	longint      cycle;
	logic [31:0] rng_state;
	int          errors;
	int          checks;
	int          test_errs;
	int          tests_run;
	int          tests_failed;

	arkvid_top uut (
		.clk_48m(clk_48m), .rst_n_i(rst_n_i),
		.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata),
		.prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
		.video_r_o(video_r), .video_g_o(video_g), .video_b_o(video_b),
		.video_hsync_o(video_hsync), .video_vsync_o(video_vsync),
		.video_csync_o(video_csync), .video_hblank_o(video_hblank),
		.video_vblank_o(video_vblank)
	);

	always #5 clk_48m = ~clk_48m;

	// ==========================================================
	// Reference model
	// ==========================================================

	// Steps on every 8th clock after reset and watches the bus for writes
	always @(posedge clk_48m) begin
		cycle = cycle + 1;
		if (!rst_n_i) begin
			m_div = 0;
			m_h = H_START;
			m_v = V_BASE;
			ctrl_m = '0;
			settle = 0;
			for (int k = 0; k <= PIPE_DEPTH; k++) begin
				h_hist[k] = H_START;
				v_hist[k] = V_BASE;
			end
		end else begin
			if (m_div == PIX_DIV - 1) begin
				m_div = 0;
				// The line step uses the centering value held before any write
				if (m_h == H_START) begin
					if (m_v >= CNT_MAX - cnt_t'(ctrl_m[CTRL_VCENTER_LSB +: 3])) begin
						m_v = V_BASE - cnt_t'(ctrl_m[CTRL_VCENTER_LSB +: 3]);
					end else begin
						m_v = m_v + 1'b1;
					end
				end
				m_h = (m_h == CNT_MAX) ? H_START : m_h + 1'b1;
				for (int k = PIPE_DEPTH; k > 0; k--) begin
					h_hist[k] = h_hist[k-1];
					v_hist[k] = v_hist[k-1];
				end
				h_hist[0] = m_h;
				v_hist[0] = m_v;
				if (settle < 1000000) begin
					settle = settle + 1;
				end
			end else begin
				m_div = m_div + 1;
			end
			// Writes complete in the first access cycle
			if (psel && penable && pwrite) begin
				settle = 0;
				if (paddr >= TILE_BASE && paddr < TILE_BASE + TILE_MAP_DEPTH * 4) begin
					tile_m[(paddr - TILE_BASE) >> 2] = pwdata[7:0];
				end else if (paddr >= PAL_BASE && paddr < PAL_BASE + PAL_DEPTH * 4) begin
					pal_m[(paddr - PAL_BASE) >> 2] = pwdata[11:0];
				end else if (paddr[12:2] == CTRL_ADDR[12:2]) begin
					ctrl_m = pwdata & CTRL_MASK;
				end
			end
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic in_hblank(input cnt_t h);
		return (h > HBLANK_LO) && (h < HBLANK_HI);
	endfunction

	function automatic logic in_vblank(input cnt_t v);
		return (v < VBLANK_LO) || (v > VBLANK_HI);
	endfunction

	// Window edges move left by h_center bits 2:0, bit 3 picks the wide pair
	function automatic logic hsync_rule(input cnt_t h, input logic [3:0] hc);
		logic [6:0] lo;
		logic [6:0] hi;
		lo = (hc[3] ? HSYNC_LO_WIDE : HSYNC_LO_NARROW) - 7'(hc[2:0]);
		hi = (hc[3] ? HSYNC_HI_WIDE : HSYNC_HI_NARROW) - 7'(hc[2:0]);
		return !h[8] && (h[6:0] > lo) && (h[6:0] < hi);
	endfunction

	// Active low for the first VSYNC_LINES lines of the frame
	function automatic logic vsync_rule(input cnt_t v, input logic [2:0] vc);
		cnt_t vs;
		vs = V_BASE - cnt_t'(vc);
		return !((v >= vs) && (v <= vs + VSYNC_LINES - 1'b1));
	endfunction

	// Output flag picked by index: 0 hsync, 1 vsync, 2 hblank
	function automatic logic sync_level(input int which);
		case (which)
			0: return video_hsync;
			1: return video_vsync;
			default: return video_hblank;
		endcase
	endfunction

	// ==========================================================
	// Checks and bus tasks
	// ==========================================================

	task automatic abort_run(input string why);
		$display("ERROR: %s", why);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			errors++;
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("test %-10s ok", name);
		end else begin
			tests_failed++;
			$display("test %-10s %0d mismatches", name, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic apb_transfer(input logic wr, input logic [12:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int n;
		int exp_n;
		bit done;
		// RAM reads hold pready low for one wait cycle, all else completes at once
		exp_n = (!wr && addr < CTRL_ADDR) ? 2 : 1;
		@(posedge clk_48m);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk_48m);
		#1;
		penable = 1'b1;
		done = 0;
		n = 0;
		while (!done) begin
			if (n >= APB_LIMIT) begin
				abort_run("APB transfer never saw pready");
			end
			@(negedge clk_48m);
			if (pready) begin
				done = 1;
				rdata = prdata;
				err = pslverr;
			end
			n++;
		end
		check_value("apb pready cycles", 32'(exp_n), 32'(n));
		@(posedge clk_48m);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [12:0] addr, input logic [31:0] wdata, output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, wdata, unused, err);
	endtask

	task automatic apb_read(input logic [12:0] addr, output logic [31:0] rdata, output logic err);
		apb_transfer(1'b0, addr, 32'd0, rdata, err);
	endtask

	// Output flags change only on a rising edge, so negedge samples are stable
	task automatic wait_level(input int which, input logic level, input int limit,
			input string what);
		int n;
		n = 0;
		while (sync_level(which) !== level) begin
			if (n >= limit) begin
				abort_run({"timed out waiting for ", what});
			end
			@(negedge clk_48m);
			n++;
		end
	endtask

	task automatic next_edge(input int which, input logic level, input int limit,
			input string what, output longint t);
		wait_level(which, ~level, limit, what);
		wait_level(which, level, limit, what);
		t = cycle;
	endtask

	// Compares the outputs with the model position PIPE_DEPTH enables back
	task automatic check_pixel(input string name);
		cnt_t       h;
		cnt_t       v;
		logic [4:0] cx;
		logic [4:0] cy;
		tile_code_t code;
		rgb_t       exp_rgb;
		logic       hb;
		logic       vb;
		logic       hs;
		logic       vs;
		h = h_hist[PIPE_DEPTH];
		v = v_hist[PIPE_DEPTH];
		hb = in_hblank(h);
		vb = in_vblank(v);
		cx = h[7:3] ^ {5{ctrl_m[CTRL_HFLIP_BIT]}};
		cy = v[7:3] ^ {5{ctrl_m[CTRL_VFLIP_BIT]}};
		code = tile_m[{cy, cx}];
		exp_rgb = (hb || vb) ? rgb_t'(0) : pal_m[{ctrl_m[CTRL_BANK_BIT], code}];
		hs = hsync_rule(h, ctrl_m[CTRL_HCENTER_LSB +: 4]);
		vs = vsync_rule(v, ctrl_m[CTRL_VCENTER_LSB +: 3]);
		check_value({name, " rgb"}, 32'(exp_rgb), 32'({video_r, video_g, video_b}));
		check_value({name, " hblank"}, 32'(hb), 32'(video_hblank));
		check_value({name, " vblank"}, 32'(vb), 32'(video_vblank));
		check_value({name, " hsync"}, 32'(hs), 32'(video_hsync));
		check_value({name, " vsync"}, 32'(vs), 32'(video_vsync));
		check_value({name, " csync"}, 32'(hs ^ vs), 32'(video_csync));
	endtask

	// Random gaps spread the samples over most of a frame
	task automatic sample_pixels(input string name, input int count, input logic want_blank);
		int got;
		int tries;
		int gap;
		got = 0;
		tries = 0;
		while (got < count) begin
			if (tries >= count * 64) begin
				abort_run({"too few usable pixel samples in ", name});
			end
			tries++;
			gap = int'(next_random() % 4096);
			repeat (gap) @(negedge clk_48m);
			@(negedge clk_48m);
			if (settle >= PIPE_DEPTH + 1) begin
				if ((in_hblank(h_hist[PIPE_DEPTH]) || in_vblank(v_hist[PIPE_DEPTH])) == want_blank) begin
					check_pixel(name);
					got++;
				end
			end
		end
	endtask

	// ==========================================================
	// Test sequence
	// ==========================================================

	initial begin
		longint      t0;
		longint      t1;
		longint      t2;
		logic [31:0] rdata;
		logic [31:0] expected;
		logic        err;
		logic [3:0]  hc;
		int          sel;
		int          idx;
		int          width;
		int          hs_first;
		int          hb_first;
		logic [12:0] addr;

		clk_48m = 1'b0;
		rst_n_i = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		cycle = 0;
		rng_state = 32'hf8ad71d6;
		errors = 0;
		checks = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (4) @(posedge clk_48m);
		#1;
		rst_n_i = 1'b1;

		// Line and frame periods from the output sync edges
		next_edge(0, 1'b1, 2 * LINE_CLKS, "hsync rise", t0);
		next_edge(0, 1'b1, 2 * LINE_CLKS, "hsync rise", t1);
		check_value("timing hsync period", LINE_CLKS, 32'(t1 - t0));
		next_edge(1, 1'b0, 2 * FRAME_LINES * LINE_CLKS, "vsync fall", t0);
		next_edge(1, 1'b0, 2 * FRAME_LINES * LINE_CLKS, "vsync fall", t1);
		check_value("timing vsync period", FRAME_LINES * LINE_CLKS, 32'(t1 - t0));
		for (int s = 0; s < 2; s++) begin
			hc = (s == 0) ? 4'h0 : 4'hb;
			apb_write(CTRL_ADDR, 32'(hc) << CTRL_HCENTER_LSB, err);
			width = 0;
			hs_first = -1;
			hb_first = -1;
			for (int h = int'(H_START); h <= int'(CNT_MAX); h++) begin
				width += hsync_rule(cnt_t'(h), hc);
				if (hs_first < 0 && hsync_rule(cnt_t'(h), hc)) begin
					hs_first = h;
				end
				if (hb_first < 0 && in_hblank(cnt_t'(h))) begin
					hb_first = h;
				end
			end
			// Hblank starts ahead of the pulse, so the next pulse uses the new window
			next_edge(2, 1'b1, 2 * LINE_CLKS, "hblank rise", t2);
			next_edge(0, 1'b1, 2 * LINE_CLKS, "hsync rise", t0);
			next_edge(0, 1'b0, 2 * LINE_CLKS, "hsync fall", t1);
			check_value("timing hsync offset", hs_first - hb_first, 32'((t0 - t2) / PIX_DIV));
			check_value("timing hsync width", width, 32'((t1 - t0) / PIX_DIV));
		end
		apb_write(CTRL_ADDR, 32'd0, err);
		finish_test("timing");

		// Random write and read back over all three regions
		for (int i = 0; i < 48; i++) begin
			sel = int'(next_random() % 3);
			idx = int'(next_random() % ((sel == 0) ? TILE_MAP_DEPTH : PAL_DEPTH));
			if (sel == 0) begin
				addr = TILE_BASE + 13'(idx * 4);
			end else if (sel == 1) begin
				addr = PAL_BASE + 13'(idx * 4);
			end else begin
				addr = CTRL_ADDR;
			end
			apb_write(addr, next_random(), err);
			check_value("regs write pslverr", 32'd0, 32'(err));
			apb_read(addr, rdata, err);
			check_value("regs read pslverr", 32'd0, 32'(err));
			if (sel == 0) begin
				expected = 32'(tile_m[idx]);
			end else if (sel == 1) begin
				expected = 32'(pal_m[idx]);
			end else begin
				expected = ctrl_m;
			end
			check_value("regs readback", expected, rdata);
		end
		for (int i = 0; i < 4; i++) begin
			addr = CTRL_ADDR + 13'd4 + 13'((next_random() % 511) * 4);
			apb_write(addr, next_random(), err);
			check_value("regs unmapped write pslverr", 32'd1, 32'(err));
			apb_read(addr, rdata, err);
			check_value("regs unmapped read pslverr", 32'd1, 32'(err));
			check_value("regs unmapped read data", 32'd0, rdata);
			apb_read(CTRL_ADDR, rdata, err);
			check_value("regs ctrl after error", ctrl_m, rdata);
		end
		apb_write(CTRL_ADDR, 32'd0, err);
		finish_test("regs");

		// Fill both memories, then compare visible pixels
		for (int i = 0; i < TILE_MAP_DEPTH; i++) begin
			apb_write(TILE_BASE + 13'(i * 4), next_random(), err);
		end
		for (int i = 0; i < PAL_DEPTH; i++) begin
			apb_write(PAL_BASE + 13'(i * 4), next_random(), err);
		end
		sample_pixels("pixel", 200, 1'b0);
		finish_test("pixel");

		apb_write(CTRL_ADDR, (32'h1 << CTRL_HFLIP_BIT) | (32'h1 << CTRL_VFLIP_BIT)
			| (32'h1 << CTRL_BANK_BIT), err);
		sample_pixels("flip", 150, 1'b0);
		finish_test("flip");

		sample_pixels("blank", 100, 1'b1);
		finish_test("blank");

		$display("tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, uut.u_checker.assert_fails);
		if (errors == 0 && uut.u_checker.assert_fails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- tests/arkvid_checker.sv
/*
 * Concurrent assertions on the APB handshake and the output blanking of
 * the video core. Bound into the top level at the end of this file.
 */
`timescale 1ns/1ns

module arkvid_checker (
	input logic       clk_48m,
	input logic       rst_n_i,
	input logic       psel_i,
	input logic       penable_i,
	input logic       pready_o,
	input logic       pslverr_o,
	input logic [3:0] video_r_o,
	input logic [3:0] video_g_o,
	input logic [3:0] video_b_o,
	input logic       video_hblank_o,
	input logic       video_vblank_o
);

	// Number of assertion failures so far
	int assert_fails = 0;

	// A transfer may only complete inside an access phase
	ready_in_access: assert property (@(posedge clk_48m) disable iff (!rst_n_i)
		pready_o |-> (psel_i && penable_i))
		else begin
			assert_fails++;
			$error("pready high outside an APB access phase");
		end

	// The error flag is only meaningful on the completing cycle
	slverr_with_ready: assert property (@(posedge clk_48m) disable iff (!rst_n_i)
		pslverr_o |-> pready_o)
		else begin
			assert_fails++;
			$error("pslverr high without pready");
		end

	// Black is forced whenever either blank output is set
	black_in_blank: assert property (@(posedge clk_48m) disable iff (!rst_n_i)
		(video_hblank_o || video_vblank_o) |-> ({video_r_o, video_g_o, video_b_o} == 12'd0))
		else begin
			assert_fails++;
			$error("nonzero RGB during blanking");
		end

endmodule

bind arkvid_top arkvid_checker u_checker (.*);

//--- source/arkvid_top.sv
/*
 * Top level of the tilemap video core. Connects the raster timing, the
 * tile and palette stages with their RAMs, the output stage and the
 * APB slave used by the host to load the map and palette.
 */
`timescale 1ns/1ns

module arkvid_top import arkvid_pkg::*; (
	input  logic              clk_48m,
	input  logic              rst_n_i,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [APB_AW-1:0] paddr_i,
	input  logic [31:0]       pwdata_i,
	output logic [31:0]       prdata_o,
	output logic              pready_o,
	output logic              pslverr_o,
	output logic [3:0]        video_r_o,
	output logic [3:0]        video_g_o,
	output logic [3:0]        video_b_o,
	output logic              video_hsync_o,
	output logic              video_vsync_o,
	output logic              video_csync_o,
	output logic              video_hblank_o,
	output logic              video_vblank_o
);

	// Control register fields
	logic       hflip;
	logic       vflip;
	logic       pal_bank;
	logic [3:0] h_center;
	logic [2:0] v_center;

	// Raster position and its decoded flags
	logic pix_cen;
	cnt_t h_cnt;
	cnt_t v_cnt;
	logic hsync;
	logic vsync;
	logic hblank;
	logic vblank;

	// Video side of both RAMs
	logic [TILE_AW-1:0] tile_addr_a;
	tile_code_t         tile_rdata_a;
	tile_code_t         tile_code;
	logic [PAL_AW-1:0]  pal_addr_a;
	rgb_t               pal_rdata_a;
	rgb_t               rgb;

	// Host side of both RAMs
	logic [TILE_AW-1:0] tile_addr_b;
	logic               tile_we_b;
	tile_code_t         tile_wdata_b;
	tile_code_t         tile_rdata_b;
	logic [PAL_AW-1:0]  pal_addr_b;
	logic               pal_we_b;
	rgb_t               pal_wdata_b;
	rgb_t               pal_rdata_b;

	// ==========================================================
	// Host access
	// ==========================================================

	apb_regs u_apb (
		.clk_48m, .rst_n_i,
		.psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
		.prdata_o, .pready_o, .pslverr_o,
		.hflip_o(hflip), .vflip_o(vflip), .pal_bank_o(pal_bank),
		.h_center_o(h_center), .v_center_o(v_center),
		.tile_addr_o(tile_addr_b), .tile_we_o(tile_we_b),
		.tile_wdata_o(tile_wdata_b), .tile_rdata_i(tile_rdata_b),
		.pal_addr_o(pal_addr_b), .pal_we_o(pal_we_b),
		.pal_wdata_o(pal_wdata_b), .pal_rdata_i(pal_rdata_b)
	);

	video_ram #(.entry_t(tile_code_t), .DEPTH(TILE_MAP_DEPTH)) u_tile_ram (
		.clk_48m,
		.a_addr_i(tile_addr_a), .a_rdata_o(tile_rdata_a),
		.b_addr_i(tile_addr_b), .b_we_i(tile_we_b),
		.b_wdata_i(tile_wdata_b), .b_rdata_o(tile_rdata_b)
	);

	video_ram #(.entry_t(rgb_t), .DEPTH(PAL_DEPTH)) u_pal_ram (
		.clk_48m,
		.a_addr_i(pal_addr_a), .a_rdata_o(pal_rdata_a),
		.b_addr_i(pal_addr_b), .b_we_i(pal_we_b),
		.b_wdata_i(pal_wdata_b), .b_rdata_o(pal_rdata_b)
	);

	// ==========================================================
	// Pixel pipeline
	// ==========================================================

	video_timing u_timing (
		.clk_48m, .rst_n_i,
		.h_center_i(h_center), .v_center_i(v_center),
		.pix_cen_o(pix_cen), .h_cnt_o(h_cnt), .v_cnt_o(v_cnt),
		.hsync_o(hsync), .vsync_o(vsync), .hblank_o(hblank), .vblank_o(vblank)
	);

	tile_fetch u_tile (
		.clk_48m, .rst_n_i, .pix_cen_i(pix_cen),
		.h_cnt_i(h_cnt), .v_cnt_i(v_cnt), .hflip_i(hflip), .vflip_i(vflip),
		.tile_code_o(tile_code), .tile_addr_o(tile_addr_a), .tile_rdata_i(tile_rdata_a)
	);

	palette_lookup u_pal (
		.clk_48m, .rst_n_i, .pix_cen_i(pix_cen),
		.pal_bank_i(pal_bank), .tile_code_i(tile_code), .rgb_o(rgb),
		.pal_addr_o(pal_addr_a), .pal_rdata_i(pal_rdata_a)
	);

	video_output u_out (
		.clk_48m, .rst_n_i, .pix_cen_i(pix_cen), .rgb_i(rgb),
		.hsync_i(hsync), .vsync_i(vsync), .hblank_i(hblank), .vblank_i(vblank),
		.video_r_o, .video_g_o, .video_b_o,
		.video_hsync_o, .video_vsync_o, .video_csync_o,
		.video_hblank_o, .video_vblank_o
	);

endmodule

//--- source/video_output.sv
/*
 * Last pipeline stage: delays sync and blank to line up with the colour
 * data, then registers the video outputs with black forced in blanking.
 */
`timescale 1ns/1ns

module video_output import arkvid_pkg::*; (
	input  logic       clk_48m,
	input  logic       rst_n_i,
	input  logic       pix_cen_i,
	input  rgb_t       rgb_i,
	input  logic       hsync_i,
	input  logic       vsync_i,
	input  logic       hblank_i,
	input  logic       vblank_i,
	output logic [3:0] video_r_o,
	output logic [3:0] video_g_o,
	output logic [3:0] video_b_o,
	output logic       video_hsync_o,
	output logic       video_vsync_o,
	output logic       video_csync_o,
	output logic       video_hblank_o,
	output logic       video_vblank_o
);

	logic [1:0] hsync_d;
	logic [1:0] vsync_d;
	logic [1:0] hblank_d;
	logic [1:0] vblank_d;

	// Two stages match the tile and palette registers
	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			hsync_d  <= 2'b00;
			vsync_d  <= 2'b11;
			hblank_d <= 2'b00;
			vblank_d <= 2'b00;
		end else if (pix_cen_i) begin
			hsync_d  <= {hsync_d[0], hsync_i};
			vsync_d  <= {vsync_d[0], vsync_i};
			hblank_d <= {hblank_d[0], hblank_i};
			vblank_d <= {vblank_d[0], vblank_i};
		end
	end

	// ==========================================================
	// Output register
	// ==========================================================

	// Vsync idles high, so csync idles high as well
	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			{video_r_o, video_g_o, video_b_o} <= '0;
			video_hsync_o  <= 1'b0;
			video_vsync_o  <= 1'b1;
			video_csync_o  <= 1'b1;
			video_hblank_o <= 1'b0;
			video_vblank_o <= 1'b0;
		end else if (pix_cen_i) begin
			// Black whenever either blank is active
			if (hblank_d[1] || vblank_d[1]) begin
				{video_r_o, video_g_o, video_b_o} <= '0;
			end else begin
				{video_r_o, video_g_o, video_b_o} <= rgb_i;
			end
			video_hsync_o  <= hsync_d[1];
			video_vsync_o  <= vsync_d[1];
			video_csync_o  <= hsync_d[1] ^ vsync_d[1];
			video_hblank_o <= hblank_d[1];
			video_vblank_o <= vblank_d[1];
		end
	end

endmodule

//--- source/palette_lookup.sv
/*
 * Second pipeline stage: looks the tile code up in the selected palette
 * bank and holds the resulting colour for one pixel.
 */
`timescale 1ns/1ns

module palette_lookup import arkvid_pkg::*; (
	input  logic              clk_48m,
	input  logic              rst_n_i,
	input  logic              pix_cen_i,
	input  logic              pal_bank_i,
	input  tile_code_t        tile_code_i,
	output rgb_t              rgb_o,
	output logic [PAL_AW-1:0] pal_addr_o,
	input  rgb_t              pal_rdata_i
);

	rgb_t rgb_q;

	// Bank bit selects the upper or lower 256 entries
	assign pal_addr_o = {pal_bank_i, tile_code_i};

	// Colour is captured on the enable after the code changed
	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			rgb_q <= '0;
		end else if (pix_cen_i) begin
			rgb_q <= pal_rdata_i;
		end
	end

	assign rgb_o = rgb_q;

endmodule

//--- source/tile_fetch.sv
/*
 * First pipeline stage: turns the raster position into a tile map cell
 * address, honouring the flip bits, and captures the returned tile code
 * on the pixel enable.
 */
`timescale 1ns/1ns

module tile_fetch import arkvid_pkg::*; (
	input  logic               clk_48m,
	input  logic               rst_n_i,
	input  logic               pix_cen_i,
	input  cnt_t               h_cnt_i,
	input  cnt_t               v_cnt_i,
	input  logic               hflip_i,
	input  logic               vflip_i,
	output tile_code_t         tile_code_o,
	output logic [TILE_AW-1:0] tile_addr_o,
	input  tile_code_t         tile_rdata_i
);

	logic [4:0] cell_x;
	logic [4:0] cell_y;
	tile_code_t code_q;

	// Each cell is 8x8 pixels, so bits 7:3 pick the column and row
	// Flipping a screen axis just inverts those bits
	assign cell_x = h_cnt_i[7:3] ^ {5{hflip_i}};
	assign cell_y = v_cnt_i[7:3] ^ {5{vflip_i}};

	// Row-major map with 32 cells per row
	assign tile_addr_o = {cell_y, cell_x};

	// Counters move on pix_cen and the RAM answers one clock later,
	// so the code is stable well before the next enable
	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			code_q <= '0;
		end else if (pix_cen_i) begin
			code_q <= tile_rdata_i;
		end
	end

	assign tile_code_o = code_q;

endmodule

//--- source/video_ram.sv
/*
 * Dual-port synchronous RAM for tile codes or palette entries.
 * Port A is a read-only video port, port B the read/write host port.
 */
`timescale 1ns/1ns

module video_ram #(
	parameter type entry_t = logic [7:0],
	parameter int  DEPTH   = 1024
) (
	input  logic                     clk_48m,
	input  logic [$clog2(DEPTH)-1:0] a_addr_i,
	output entry_t                   a_rdata_o,
	input  logic [$clog2(DEPTH)-1:0] b_addr_i,
	input  logic                     b_we_i,
	input  entry_t                   b_wdata_i,
	output entry_t                   b_rdata_o
);

	entry_t mem [DEPTH];

	// Both ports read one clock after the address is presented
	// On a port B write the old word comes back on b_rdata_o
	always_ff @(posedge clk_48m) begin
		a_rdata_o <= mem[a_addr_i];
		b_rdata_o <= mem[b_addr_i];
		if (b_we_i) begin
			mem[b_addr_i] <= b_wdata_i;
		end
	end

endmodule

//--- source/apb_regs.sv
/*
 * APB slave giving the host access to the tile map, the palette and the
 * control register. RAM reads take one wait state, all else completes in
 * the first access cycle. Unmapped addresses answer with pslverr.
 */
`timescale 1ns/1ns

module apb_regs import arkvid_pkg::*; (
	input  logic               clk_48m,
	input  logic               rst_n_i,
	input  logic               psel_i,
	input  logic               penable_i,
	input  logic               pwrite_i,
	input  logic [APB_AW-1:0]  paddr_i,
	input  logic [31:0]        pwdata_i,
	output logic [31:0]        prdata_o,
	output logic               pready_o,
	output logic               pslverr_o,
	output logic               hflip_o,
	output logic               vflip_o,
	output logic               pal_bank_o,
	output logic [3:0]         h_center_o,
	output logic [2:0]         v_center_o,
	output logic [TILE_AW-1:0] tile_addr_o,
	output logic               tile_we_o,
	output tile_code_t         tile_wdata_o,
	input  tile_code_t         tile_rdata_i,
	output logic [PAL_AW-1:0]  pal_addr_o,
	output logic               pal_we_o,
	output rgb_t               pal_wdata_o,
	input  rgb_t               pal_rdata_i
);

	logic        access;
	logic        sel_tile;
	logic        sel_pal;
	logic        sel_ctrl;
	logic        sel_err;
	logic        ram_rd;
	logic        rd_wait_q;
	logic [31:0] ctrl_rdata;

	// Region decode works on word addresses; byte lanes are ignored
	assign sel_tile = (paddr_i[12] == TILE_BASE[12]);
	assign sel_pal  = (paddr_i[12:11] == PAL_BASE[12:11]);
	assign sel_ctrl = (paddr_i[12:2] == CTRL_ADDR[12:2]);
	assign sel_err  = !(sel_tile || sel_pal || sel_ctrl);

	assign access = psel_i && penable_i;
	assign ram_rd = !pwrite_i && (sel_tile || sel_pal);

	// The wait bit covers the one clock of RAM read latency
	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			rd_wait_q <= 1'b0;
		end else begin
			rd_wait_q <= access && ram_rd && !rd_wait_q;
		end
	end

	assign pready_o  = access && (!ram_rd || rd_wait_q);
	assign pslverr_o = access && sel_err;

	// ==========================================================
	// RAM host ports
	// ==========================================================

	// Address and data go straight to port B, the write lasts one clock
	assign tile_addr_o  = paddr_i[TILE_AW+1:2];
	assign tile_wdata_o = tile_code_t'(pwdata_i[7:0]);
	assign tile_we_o    = access && pwrite_i && sel_tile;

	assign pal_addr_o  = paddr_i[PAL_AW+1:2];
	assign pal_wdata_o = rgb_t'(pwdata_i[11:0]);
	assign pal_we_o    = access && pwrite_i && sel_pal;

	// Control register holds flips, palette bank and centering
	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			hflip_o    <= 1'b0;
			vflip_o    <= 1'b0;
			pal_bank_o <= 1'b0;
			v_center_o <= '0;
			h_center_o <= '0;
		end else if (access && pwrite_i && sel_ctrl) begin
			hflip_o    <= pwdata_i[CTRL_HFLIP_BIT];
			vflip_o    <= pwdata_i[CTRL_VFLIP_BIT];
			pal_bank_o <= pwdata_i[CTRL_BANK_BIT];
			v_center_o <= pwdata_i[CTRL_VCENTER_LSB +: 3];
			h_center_o <= pwdata_i[CTRL_HCENTER_LSB +: 4];
		end
	end

	// Bits without a field read back as zero
	always_comb begin
		ctrl_rdata = '0;
		ctrl_rdata[CTRL_HFLIP_BIT] = hflip_o;
		ctrl_rdata[CTRL_VFLIP_BIT] = vflip_o;
		ctrl_rdata[CTRL_BANK_BIT] = pal_bank_o;
		ctrl_rdata[CTRL_VCENTER_LSB +: 3] = v_center_o;
		ctrl_rdata[CTRL_HCENTER_LSB +: 4] = h_center_o;
	end

	// Read mux; an erroring read returns zero
	always_comb begin
		if (sel_ctrl) begin
			prdata_o = ctrl_rdata;
		end else if (sel_pal) begin
			prdata_o = {20'd0, pal_rdata_i};
		end else if (sel_tile) begin
			prdata_o = {24'd0, tile_rdata_i};
		end else begin
			prdata_o = '0;
		end
	end

endmodule

//--- source/video_timing.sv
/*
 * Raster timing: divides the 48 MHz clock down to a 6 MHz pixel enable,
 * runs the horizontal and vertical counters and decodes sync and blank.
 */
`timescale 1ns/1ns

module video_timing import arkvid_pkg::*; (
	input  logic       clk_48m,
	input  logic       rst_n_i,
	input  logic [3:0] h_center_i,
	input  logic [2:0] v_center_i,
	output logic       pix_cen_o,
	output cnt_t       h_cnt_o,
	output cnt_t       v_cnt_o,
	output logic       hsync_o,
	output logic       vsync_o,
	output logic       hblank_o,
	output logic       vblank_o
);

	logic [DIV_W-1:0] div_q;
	cnt_t             h_q;
	cnt_t             v_q;
	cnt_t             v_start;
	cnt_t             v_end;
	logic [6:0]       hs_lo;
	logic [6:0]       hs_hi;

	// Pixel enable is high for one clock out of every PIX_DIV
	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			div_q <= '0;
		end else if (div_q == DIV_W'(PIX_DIV - 1)) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	assign pix_cen_o = (div_q == DIV_W'(PIX_DIV - 1));

	// Vertical centering moves both ends of the line range together
	assign v_start = V_BASE - cnt_t'(v_center_i);
	assign v_end   = CNT_MAX - cnt_t'(v_center_i);

	// ==========================================================
	// Raster counters
	// ==========================================================

	// H wraps from 511 to 128, giving 384 pixels per line
	// V steps once per line, at the moment h leaves 128
	always_ff @(posedge clk_48m) begin
		if (!rst_n_i) begin
			h_q <= H_START;
			v_q <= V_BASE;
		end else if (pix_cen_o) begin
			h_q <= (h_q == CNT_MAX) ? H_START : h_q + 1'b1;
			if (h_q == H_START) begin
				v_q <= (v_q >= v_end) ? v_start : v_q + 1'b1;
			end
		end
	end

	assign h_cnt_o = h_q;
	assign v_cnt_o = v_q;

	// ==========================================================
	// Sync and blank decode
	// ==========================================================

	// h_center bit 3 picks the wide window, bits 2:0 slide it left
	assign hs_lo = (h_center_i[3] ? HSYNC_LO_WIDE : HSYNC_LO_NARROW) - 7'(h_center_i[2:0]);
	assign hs_hi = (h_center_i[3] ? HSYNC_HI_WIDE : HSYNC_HI_NARROW) - 7'(h_center_i[2:0]);

	assign hsync_o = !h_q[8] && (h_q[6:0] > hs_lo) && (h_q[6:0] < hs_hi);

	// Vsync is active low over the first lines of the frame
	assign vsync_o = !((v_q >= v_start) && (v_q <= v_start + VSYNC_LINES - 9'd1));

	assign hblank_o = (h_q > HBLANK_LO) && (h_q < HBLANK_HI);
	assign vblank_o = (v_q < VBLANK_LO) || (v_q > VBLANK_HI);

endmodule

//--- source/arkvid_pkg.sv
/*
 * Shared widths, raster constants, APB register map and payload types
 * for the tilemap video pipeline. Modules pull these in with a wildcard
 * import in their header.
 */
package arkvid_pkg;

	// ==========================================================
	// Payload types
	// ==========================================================

	// Raster counters are 9 bits wide and run from 128 to 511
	typedef logic [8:0]  cnt_t;
	typedef logic [7:0]  tile_code_t;
	// Colour is packed red, green, blue with 4 bits each
	typedef logic [11:0] rgb_t;

	// ==========================================================
	// Raster constants
	// ==========================================================

	localparam cnt_t H_START     = 9'd128;
	localparam cnt_t CNT_MAX     = 9'd511;
	localparam cnt_t V_BASE      = 9'd248;
	localparam cnt_t HBLANK_LO   = 9'd137;
	localparam cnt_t HBLANK_HI   = 9'd266;
	localparam cnt_t VBLANK_LO   = 9'd271;
	localparam cnt_t VBLANK_HI   = 9'd495;
	localparam cnt_t VSYNC_LINES = 9'd8;

	// Hsync window edges compare against h bits 6:0 only
	localparam logic [6:0] HSYNC_LO_NARROW = 7'd47;
	localparam logic [6:0] HSYNC_HI_NARROW = 7'd80;
	localparam logic [6:0] HSYNC_LO_WIDE   = 7'd54;
	localparam logic [6:0] HSYNC_HI_WIDE   = 7'd87;

	// 48 MHz divided by 8 gives the 6 MHz pixel enable
	localparam int PIX_DIV    = 8;
	localparam int DIV_W      = $clog2(PIX_DIV);
	localparam int PIPE_DEPTH = 3;

	// ==========================================================
	// Memories and APB map
	// ==========================================================

	localparam int TILE_MAP_DEPTH = 1024;
	localparam int PAL_DEPTH      = 512;
	localparam int TILE_AW        = $clog2(TILE_MAP_DEPTH);
	localparam int PAL_AW         = $clog2(PAL_DEPTH);

	localparam int APB_AW = 13;
	localparam logic [APB_AW-1:0] TILE_BASE = 13'h0000;
	localparam logic [APB_AW-1:0] PAL_BASE  = 13'h1000;
	localparam logic [APB_AW-1:0] CTRL_ADDR = 13'h1800;

	// Control register layout
	localparam int CTRL_HFLIP_BIT   = 0;
	localparam int CTRL_VFLIP_BIT   = 1;
	localparam int CTRL_BANK_BIT    = 2;
	localparam int CTRL_VCENTER_LSB = 4;
	localparam int CTRL_HCENTER_LSB = 8;

endpackage
